// ==== source/mcr_input_defines.svh ====
// Constants for the MCR3 player input front end
// Key codes are matched against ps2_key[7:0] only. The extended-key
// flag in bit 8 is ignored, so extended and plain keys with the same
// code share one state bit.
`ifndef MCR_INPUT_DEFINES_SVH
`define MCR_INPUT_DEFINES_SVH

`define NUM_PLAYERS 4 // Players and wheel spinners
`define WHEEL_BITS 6 // Wheel angle width, wraps modulo 64
`define WHEEL_STEP 1 // Angle change per vsync strobe

// ========================================
// Player 1 keys
`define KEY_UP 8'h75
`define KEY_DOWN 8'h72
`define KEY_LEFT 8'h6B
`define KEY_RIGHT 8'h74
`define KEY_LCTRL 8'h14 // Fire A
`define KEY_LALT 8'h11 // Fire B
`define KEY_F1 8'h05 // Start 1
`define KEY_1 8'h16 // Start 1
`define KEY_ESC 8'h76 // Coin 1
`define KEY_5 8'h2E // Coin 1

// ========================================
// Player 2 keys, coins 2 and 3 feed the shared coin
`define KEY_D 8'h23 // Left
`define KEY_G 8'h34 // Right
`define KEY_A 8'h1C // Fire A
`define KEY_S 8'h1B // Fire B
`define KEY_F2 8'h06 // Start 2
`define KEY_2 8'h1E // Start 2
`define KEY_6 8'h36 // Coin 2
`define KEY_7 8'h3D // Coin 3

// ========================================
// Bit positions in a joystick word
`define JOY_RIGHT 0
`define JOY_LEFT 1
`define JOY_DOWN 2
`define JOY_UP 3
`define JOY_FIRE_A 4
`define JOY_FIRE_B 5
`define JOY_START 8
`define JOY_COIN 9

`endif

// ==== source/mcr_input_pkg.sv ====
// Types shared by the player input front end
// All control bits are active high here; the port builder inverts
// them for the game's active-low input ports.
package mcr_input_pkg;

	// Joystick word as received from the host, only bits 9:0 carry controls
	typedef logic [15:0] joy_word_t;

	// One player's merged controls
	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
		logic fire_a;
		logic fire_b;
		logic start;
		logic coin;
	} player_ctl_t;

endpackage

// ==== source/player_merge.sv ====
// Keyboard event decoder and joystick merge for four players
// A key event is taken whenever ps2_key[10] toggles; the pressed
// flag in bit 9 is stored for the matching key. Only players 1 and 2
// have keys. All coins fold into player 1's coin; the others read 0.
// The joystick merge is combinational.
`timescale 1ns/100ps
`include "mcr_input_defines.svh"

module player_merge
	import mcr_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	input  joy_word_t   joy_words [`NUM_PLAYERS],
	output player_ctl_t players [`NUM_PLAYERS]
);

	logic              toggle_q; // Bit 10 one cycle earlier
	logic              key_event;
	logic              key_pressed;
	logic [7:0]        key_code;
	player_ctl_t [1:0] kbd; // Key state of players 1 and 2
	logic              key_coin2;
	logic              key_coin3;

	assign key_event   = ps2_key[10] != toggle_q;
	assign key_pressed = ps2_key[9];
	assign key_code    = ps2_key[7:0];

	function automatic player_ctl_t joy_decode(input joy_word_t w);
		player_ctl_t c;
		c.left   = w[`JOY_LEFT];
		c.right  = w[`JOY_RIGHT];
		c.up     = w[`JOY_UP];
		c.down   = w[`JOY_DOWN];
		c.fire_a = w[`JOY_FIRE_A];
		c.fire_b = w[`JOY_FIRE_B];
		c.start  = w[`JOY_START];
		c.coin   = w[`JOY_COIN];
		return c;
	endfunction

	// ========================================
	// Keyboard state
	always_ff @(posedge clk_sys) begin
		toggle_q <= ps2_key[10]; // Tracks through reset, no event on release
		if (reset) begin
			kbd       <= '0;
			key_coin2 <= 1'b0;
			key_coin3 <= 1'b0;
		end else if (key_event) begin
			case (key_code)
				`KEY_UP:    kbd[0].up     <= key_pressed;
				`KEY_DOWN:  kbd[0].down   <= key_pressed;
				`KEY_LEFT:  kbd[0].left   <= key_pressed;
				`KEY_RIGHT: kbd[0].right  <= key_pressed;
				`KEY_LCTRL: kbd[0].fire_a <= key_pressed;
				`KEY_LALT:  kbd[0].fire_b <= key_pressed;
				`KEY_F1,
				`KEY_1:     kbd[0].start  <= key_pressed;
				`KEY_ESC,
				`KEY_5:     kbd[0].coin   <= key_pressed;
				`KEY_D:     kbd[1].left   <= key_pressed;
				`KEY_G:     kbd[1].right  <= key_pressed;
				`KEY_A:     kbd[1].fire_a <= key_pressed;
				`KEY_S:     kbd[1].fire_b <= key_pressed;
				`KEY_F2,
				`KEY_2:     kbd[1].start  <= key_pressed;
				`KEY_6:     key_coin2     <= key_pressed;
				`KEY_7:     key_coin3     <= key_pressed;
				default: ; // Other keys ignored
			endcase
		end
	end

	// ========================================
	// Keyboard and joystick merge
	always_comb begin
		logic any_joy_coin;
		any_joy_coin = 1'b0;
		for (int i = 0; i < `NUM_PLAYERS; i++) begin
			players[i] = joy_decode(joy_words[i]);
			any_joy_coin = any_joy_coin | players[i].coin;
		end
		players[0] = players[0] | kbd[0];
		players[1] = players[1] | kbd[1];

		// Shared coin on player 1
		players[0].coin = kbd[0].coin | key_coin2 | key_coin3 | any_joy_coin;
		for (int i = 1; i < `NUM_PLAYERS; i++) begin
			players[i].coin = 1'b0;
		end
	end

endmodule

// ==== source/wheel_spinner.sv ====
// Steering wheel angle for one player
// The strobe is a level; each rising edge moves the angle one step
// when exactly one direction is held. The angle changes two clocks
// after the strobe rises and wraps around at the top and bottom.
`timescale 1ns/100ps
`include "mcr_input_defines.svh"

module wheel_spinner (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   strobe,
	input  logic                   left,
	input  logic                   right,
	output logic [`WHEEL_BITS-1:0] angle
);

	localparam logic [`WHEEL_BITS-1:0] step = `WHEEL_STEP;

	logic strobe_q;
	logic edge_q; // Registered rising edge of strobe

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_q <= 1'b0;
			edge_q   <= 1'b0;
		end else begin
			strobe_q <= strobe;
			edge_q   <= strobe & ~strobe_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			angle <= '0;
		end else if (edge_q) begin
			if (right && !left)
				angle <= angle + step; // Clockwise
			else if (left && !right)
				angle <= angle - step;
		end
	end

	// Angle moves only two clocks after strobe rises, reset aside
	a_angle_needs_edge: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$stable(angle) && !$past(reset) && !$past(reset, 3)
			|-> $past(strobe, 2) && !$past(strobe, 3)
	);

endmodule

// ==== source/derby_port_builder.sv ====
// Demolition Derby input port assembly
// Output port 6 bit 6 routes players 3/4 onto ports 1/2 and bit 7
// routes players 1/2 back; bit 6 wins when both are written.
// All ports but port 3 are active low. Port 3 passes the DIPs as is.
`timescale 1ns/100ps
`include "mcr_input_defines.svh"

module derby_port_builder
	import mcr_input_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  player_ctl_t            players [`NUM_PLAYERS],
	input  logic [`WHEEL_BITS-1:0] angles [`NUM_PLAYERS],
	input  logic [7:0]             game_out6,
	input  logic [7:0]             dip_sw,
	input  logic                   dip_service,
	output logic [7:0]             port0,
	output logic [7:0]             port1,
	output logic [7:0]             port2,
	output logic [7:0]             port3,
	output logic [7:0]             port4
);

	logic mux_sel; // 1 selects players 3/4 on the wheel ports

	// Wheel port, angle on top and the two fires below
	function automatic logic [7:0] wheel_port(
		input logic [`WHEEL_BITS-1:0] angle,
		input player_ctl_t           ctl
	);
		return ~{angle, ctl.fire_b, ctl.fire_a};
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset)
			mux_sel <= 1'b0;
		else if (game_out6[6])
			mux_sel <= 1'b1;
		else if (game_out6[7])
			mux_sel <= 1'b0;
	end

	// ========================================
	// Input ports
	assign port0 = ~{2'b00, dip_service, 1'b0,
		players[1].start, players[0].start, 1'b0, players[0].coin};

	assign port1 = mux_sel ? wheel_port(angles[2], players[2])
		: wheel_port(angles[0], players[0]);
	assign port2 = mux_sel ? wheel_port(angles[3], players[3])
		: wheel_port(angles[1], players[1]);

	assign port3 = dip_sw;

	assign port4 = ~{players[3].fire_b, players[3].fire_a,
		players[2].fire_b, players[2].fire_a,
		players[3].start, players[2].start, 2'b00};

	a_mux_sel_known: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$isunknown(mux_sel)
	);

endmodule

// ==== source/mcr_input_top.sv ====
// Player input front end for Demolition Derby on MCR3 mono
// Keys reach the ports one clock after the ps2_key toggle; wheel
// steps reach them two clocks after vsync rises. One vsync edge moves
// every wheel by at most one step.
`timescale 1ns/100ps
`include "mcr_input_defines.svh"

module mcr_input_top
	import mcr_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	input  joy_word_t   joy_words [`NUM_PLAYERS],
	input  logic        vsync,
	input  logic [7:0]  game_out6,
	input  logic [7:0]  dip_sw,
	input  logic        dip_service,
	output logic [7:0]  port0,
	output logic [7:0]  port1,
	output logic [7:0]  port2,
	output logic [7:0]  port3,
	output logic [7:0]  port4
);

	player_ctl_t            players [`NUM_PLAYERS];
	logic [`WHEEL_BITS-1:0] angles [`NUM_PLAYERS];

	player_merge u_player_merge (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ps2_key   (ps2_key),
		.joy_words (joy_words),
		.players   (players)
	);

	// One wheel per player, all stepped by vsync
	for (genvar i = 0; i < `NUM_PLAYERS; i++) begin : g_wheel
		wheel_spinner u_wheel_spinner (
			.clk_sys (clk_sys),
			.reset   (reset),
			.strobe  (vsync),
			.left    (players[i].left),
			.right   (players[i].right),
			.angle   (angles[i])
		);
	end

	derby_port_builder u_derby_port_builder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.players     (players),
		.angles      (angles),
		.game_out6   (game_out6),
		.dip_sw      (dip_sw),
		.dip_service (dip_service),
		.port0       (port0),
		.port1       (port1),
		.port2       (port2),
		.port3       (port3),
		.port4       (port4)
	);

endmodule

// ==== bench/tb_mcr_input.sv ====
// Testbench for the MCR3 player input front end
// Commands and expected port values come from bench/mcr_input_stim.txt,
// so the run starts in the project root. Inputs change 10 ns after
// the rising clock edge and ports are sampled at the same point.
`timescale 1ns/100ps
`include "mcr_input_defines.svh"

module tb_mcr_input
	import mcr_input_pkg::*;
();

	localparam int RESET_CYCLES = 5;
	localparam int LINE_CYCLES  = 64; // Cycle budget per stim line

	logic            clk_sys = 1'b0;
	logic            reset;
	logic [10:0]     ps2_key;
	joy_word_t       joy_words [`NUM_PLAYERS];
	logic            vsync;
	logic [7:0]      game_out6;
	logic [7:0]      dip_sw;
	logic            dip_service;
	logic [7:0]      port0, port1, port2, port3, port4;
	logic [4:0][7:0] ports; // Ports by number
	logic [31:0]     stim [256];
	logic [7:0]      lfsr = 8'd48;
	int              n_lines = 0;
	int              cycle_count = 0;
	int              cycle_limit = 0;
	int              checks = 0;
	int              errors = 0;
	int              test_errors = 0;
	int              tests_run = 0;

	mcr_input_top u_mcr_input_top (.*);

	assign ports = {port4, port3, port2, port1, port0};

	always #50 clk_sys = ~clk_sys; // 100 ns period

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not end within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Wait n clocks, returning 10 ns after the last edge
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#10;
		end
	endtask

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic check_value(input logic [7:0] got, input logic [7:0] expected,
			input string what);
		checks++;
		if (got !== expected) begin
			$display("FAIL at time %0t: %s reads %h, expected %h", $time, what, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	// ========================================
	// Stim word: command 31:28, argument 27:24, value 15:0
	task automatic run_command(input logic [31:0] w);
		logic [3:0]  arg;
		logic [15:0] val;
		arg = w[27:24];
		val = w[15:0];
		case (w[31:28])
			4'd1: begin // Key event, toggle marks it new
				ps2_key = {~ps2_key[10], arg[0], 1'b0, val[7:0]};
				idle(1);
			end
			4'd2: begin
				joy_words[arg[1:0]] = val;
				idle(1);
			end
			4'd3: begin // vsync pulses 4 clocks apart
				repeat (int'(val)) begin
					vsync = 1'b1;
					idle(2);
					vsync = 1'b0;
					idle(2);
				end
			end
			4'd4: begin // One-cycle write to port 6
				game_out6 = val[7:0];
				idle(1);
				game_out6 = 8'h00;
			end
			4'd5: begin
				dip_sw      = val[7:0];
				dip_service = arg[0];
				idle(1);
			end
			4'd6: begin
				idle(4);
				check_value(ports[arg[2:0]], val[7:0], $sformatf("port %0d", arg));
			end
			4'd7: begin
				$display("Test %0d finished with %0d mismatches", arg, test_errors);
				tests_run++;
				test_errors = 0;
			end
			default: begin
				$display("Stim word %h holds an unknown command", w);
				errors++;
			end
		endcase
	endtask

	// ========================================
	initial begin
		logic [1:0] gap;
		reset       = 1'b1;
		ps2_key     = '0;
		vsync       = 1'b0;
		game_out6   = 8'h00;
		dip_sw      = 8'hA5;
		dip_service = 1'b0;
		for (int i = 0; i < `NUM_PLAYERS; i++)
			joy_words[i] = '0;
		for (int i = 0; i < 256; i++)
			stim[i] = 32'd0; // Zero marks the end of the commands
		$readmemh("bench/mcr_input_stim.txt", stim);
		while (n_lines < 255 && stim[n_lines[7:0]] != 32'd0)
			n_lines++;
		cycle_limit = n_lines * LINE_CYCLES + RESET_CYCLES;
		idle(RESET_CYCLES);
		reset = 1'b0;

		if (n_lines == 0) begin
			$display("Could not read any commands from bench/mcr_input_stim.txt");
			errors++;
		end else begin
			for (int i = 0; i < n_lines; i++) begin
				run_command(stim[i[7:0]]);
				lfsr   = lfsr_next(lfsr); // Idle gap of 0 to 3 clocks
				gap[0] = lfsr[0];
				lfsr   = lfsr_next(lfsr);
				gap[1] = lfsr[0];
				idle(int'(gap));
			end
		end

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== bench/mcr_input_stim.txt ====
// Hex word per line: cmd_arg_00_value. cmd 1 key (arg pressed), 2 joystick (arg player-1),
// 3 vsync strobes, 4 out6, 5 dip (arg service), 6 expect (arg port), 7 end of test (arg test)
6_0_00_00FF
6_1_00_00FF
6_2_00_00FF
6_3_00_00A5
6_4_00_00FF
5_1_00_00A5 // Service held from here on
6_0_00_00DF
7_1_00_0000
1_1_00_0014 // Left ctrl, fire A 1
1_1_00_003D // Key 7, shared coin
6_1_00_00FE
6_0_00_00DE
1_0_00_003D
6_0_00_00DF
7_2_00_0000
2_0_00_0010 // Joystick 1 fire A
1_0_00_0014 // Key released, joystick still holds
6_1_00_00FE
2_1_00_0100 // Joystick 2 start
2_3_00_0210 // Joystick 4 fire A and coin
6_4_00_00BF
6_0_00_00D6
7_3_00_0000
2_0_00_0001 // Right only
3_0_00_0003
6_1_00_00F3
2_0_00_0002 // Left only, wraps below zero
3_0_00_0005
6_1_00_0007
2_0_00_0003 // Both held
3_0_00_0002
6_1_00_0007
7_4_00_0000
2_2_00_0011 // Joystick 3 right and fire A
3_0_00_0002
4_0_00_00C0 // Bits 6 and 7, players 3/4
6_1_00_00F6
6_2_00_00FE
4_0_00_0080
6_1_00_0007
7_5_00_0000

// ==== mcr_input.f ====
+incdir+source
source/mcr_input_pkg.sv
source/player_merge.sv
source/wheel_spinner.sv
source/derby_port_builder.sv
source/mcr_input_top.sv
bench/tb_mcr_input.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the input front end testbench
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_mcr_input -f mcr_input.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/Vtb_mcr_input > sim.log 2>&1; then
	cat sim.log
	echo "Simulation run returned an error status"
	exit 1
fi
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
